// File: src.f
m68kBusPkg.sv
neoMapPkg.sv
regionDecoder.sv
systemLatch.sv
syncRam.sv
busCycleCtrl.sv
neoSysBus.sv
neoSysBus_sva.sv
tbNeoSysBus.sv

// File: tbNeoSysBus.sv
`timescale 1ns/1ps

module tbNeoSysBus;
	import m68kBusPkg::*;
	import neoMapPkg::*;

	localparam int cycleLimit = 64; // Clocks allowed per wait loop

	logic                    clk24M, reset;
	logic [addrWidth-1:0]    cpuAddr;   // A23 to A1
	busWordT                 cpuWriteData, cpuReadData, romData;
	logic                    cpuRead, addrStrobe, dtack, busError;
	byteStrobesT             dataStrobes; // {UDS, LDS}
	logic [romAddrWidth-1:0] romAddress;
	logic                    romCart, romRead, shadow;
	busWordT                 rdWord, wrWord;
	integer                  seed;

	neoSysBus i_neoSysBus (.*);

	always #2 clk24M = ~clk24M; // 4 ns period

	// ROM model answers only while romRead is high
	// Cart and BIOS words differ in the top byte
	assign romData = romRead ? ((romCart ? 16'h5A00 : 16'hB100) ^ romAddress[15:0]) : 'x;

	// Word the ROM model should give for a CPU byte address
	function automatic busWordT romWord(input logic cart, input logic [23:0] byteAddr);
		return (cart ? 16'h5A00 : 16'hB100) ^ byteAddr[16:1]; // Word offset
	endfunction

	task automatic failNow(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at the first error");
	endtask

	// Any failed handshake assertion ends the run
	always @(negedge clk24M)
		if (i_neoSysBus.i_busCycleCtrl.i_neoSysBus_sva.failCount != 0)
			failNow("A handshake assertion in the bus controller failed");

	task automatic compareWord(input string name, input busWordT expected, actual);
		if (actual !== expected)
			failNow($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic compareBit(input string name, input logic expected, actual);
		if (actual !== expected)
			failNow($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
	endtask

	task automatic compareCount(input string name, input int expected, actual);
		if (actual != expected)
			failNow($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
	endtask

	// Clocks from the start edge to DTACK or bus error
	task automatic awaitAck(input string name, input regionT expRegion);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk24M);
			cycles++;
			if (cycles > cycleLimit)
				failNow({"Timeout waiting for an acknowledge in ", name});
		end while (!dtack && !busError);
		compareCount({name, " latency"}, 2 + waitStates[expRegion], cycles - 1);
		compareBit({name, " dtack"}, expRegion != unmapped, dtack);
		compareBit({name, " busError"}, expRegion == unmapped, busError);
	endtask

	// Optional back-pressure before AS drops and the acknowledge goes away
	task automatic endCycle(input string name, input int hold);
		int cycles;
		repeat (hold) begin
			@(negedge clk24M);
			compareBit({name, " ack held"}, 1'b1, dtack || busError);
			compareBit({name, " romRead after ack"}, 1'b0, romRead);
			compareBit({name, " extra ram write"}, 1'b0, i_neoSysBus.workWrite);
			compareBit({name, " extra latch write"}, 1'b0, i_neoSysBus.latchWrite);
		end
		addrStrobe = 1'b0;
		cycles = 0;
		do begin
			@(negedge clk24M);
			cycles++;
			if (cycles > cycleLimit)
				failNow({"Timeout, acknowledge never released in ", name});
		end while (dtack || busError);
	endtask

	task automatic busRead(input string name, input logic [23:0] byteAddr,
			input regionT expRegion, input int hold, output busWordT data);
		@(negedge clk24M);
		cpuAddr     = byteAddr[23:1];
		cpuRead     = 1'b1;
		dataStrobes = 2'b11;
		addrStrobe  = 1'b1;
		awaitAck(name, expRegion);
		data = cpuReadData; // Valid while dtack is high
		endCycle(name, hold);
	endtask

	task automatic busWrite(input string name, input logic [23:0] byteAddr,
			input byteStrobesT strobes, input busWordT data, input regionT expRegion,
			input int hold);
		@(negedge clk24M);
		cpuAddr      = byteAddr[23:1];
		cpuRead      = 1'b0;
		dataStrobes  = strobes;
		cpuWriteData = data;
		addrStrobe   = 1'b1;
		awaitAck(name, expRegion);
		endCycle(name, hold);
	endtask

	task automatic romDecode();
		busRead("bios vector", 24'h000000, biosRom, 0, rdWord); // Vectors from BIOS
		compareWord("bios vector", romWord(1'b0, 24'h000000), rdWord);
		busRead("cart read", 24'h000400, cartRom, 0, rdWord);
		compareWord("cart read", romWord(1'b1, 24'h000400), rdWord);
		busRead("unmapped", 24'h200000, unmapped, 0, rdWord); // Bus error only
	endtask

	task automatic workRamAccess();
		for (int i = 0; i < 4; i++) begin
			wrWord = busWordT'($random(seed));
			busWrite("ram word", 24'h100040 + 24'(i * 2), 2'b11, wrWord, workRam, 0);
			busRead("ram word", 24'h100040 + 24'(i * 2), workRam, 0, rdWord);
			compareWord("ram word", wrWord, rdWord);
		end
		busWrite("ram byte", 24'h100046, 2'b01, 16'h33A5, workRam, 0); // LDS only
		busRead("ram mirror", 24'h100846, workRam, 0, rdWord); // 2 KB higher
		compareWord("ram mirror", {wrWord[15:8], 8'hA5}, rdWord);
	endtask

	// Latch value comes from A4 and the flag number from A3 to A1
	task automatic latchFlags();
		busWrite("cart vectors on", 24'h3A0013, 2'b01, '0, sysLatch, 0);
		busRead("cart vector", 24'h000004, cartRom, 0, rdWord);
		compareWord("cart vector", romWord(1'b1, 24'h000004), rdWord);
		busWrite("cart vectors off", 24'h3A0003, 2'b01, '0, sysLatch, 0);
		busRead("bios vector again", 24'h000004, biosRom, 0, rdWord);
		compareWord("bios vector again", romWord(1'b0, 24'h000004), rdWord);
		busWrite("shadow on", 24'h3A0011, 2'b01, '0, sysLatch, 0);
		compareBit("shadow on", 1'b1, shadow);
		busWrite("shadow off", 24'h3A0001, 2'b01, '0, sysLatch, 0);
		compareBit("shadow off", 1'b0, shadow);
	endtask

	task automatic paletteBanks();
		busWordT palA;
		busWordT palB;
		palA = busWordT'($random(seed));
		palB = ~palA; // Must differ from bank 0
		busWrite("palette bank 0", 24'h400100, 2'b11, palA, paletteRam, 0);
		busWrite("bank 1 select", 24'h3A001F, 2'b01, '0, sysLatch, 0);
		busWrite("palette bank 1", 24'h400100, 2'b11, palB, paletteRam, 0);
		busRead("palette bank 1", 24'h400100, paletteRam, 0, rdWord);
		compareWord("palette bank 1", palB, rdWord);
		busWrite("bank 0 select", 24'h3A000F, 2'b01, '0, sysLatch, 0);
		busRead("palette bank 0", 24'h400100, paletteRam, 0, rdWord);
		compareWord("palette bank 0", palA, rdWord);
	endtask

	task automatic heldAcknowledge();
		wrWord = busWordT'($random(seed));
		busWrite("held ram write", 24'h100100, 2'b11, wrWord, workRam, 20);
		busWrite("held latch write", 24'h3A0011, 2'b01, '0, sysLatch, 20);
		compareBit("held latch write", 1'b1, shadow);
		busRead("held rom read", 24'h000400, cartRom, 20, rdWord);
		compareWord("held rom read", romWord(1'b1, 24'h000400), rdWord);
		busRead("ram after hold", 24'h100100, workRam, 0, rdWord);
		compareWord("ram after hold", wrWord, rdWord);
	endtask

	initial begin
		seed         = 32'hf683;
		clk24M       = 1'b0;
		reset        = 1'b1;
		cpuAddr      = '0;
		cpuWriteData = '0;
		cpuRead      = 1'b1;
		dataStrobes  = '0;
		addrStrobe   = 1'b0;
		repeat (5) @(posedge clk24M);
		@(negedge clk24M);
		reset = 1'b0;
		compareBit("shadow after reset", 1'b0, shadow);
		romDecode();
		workRamAccess();
		latchFlags();
		paletteBanks();
		heldAcknowledge();
		if (i_neoSysBus.i_busCycleCtrl.i_neoSysBus_sva.failCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: neoSysBus_sva.sv
`timescale 1ns/1ps

// Handshake rules bound into the bus controller
module neoSysBus_sva (
	input logic              clk24M,
	input logic              reset,
	input logic              addrStrobe,
	input logic              dtack,
	input logic              busError,
	input logic              romRead,
	input neoMapPkg::regionT region
);
	import neoMapPkg::*;

	int failCount = 0; // Failed assertions so far

	// One kind of acknowledge per cycle
	ackExclusive: assert property (@(posedge clk24M) disable iff (reset)
		!(dtack && busError))
		else begin
			failCount++;
			$error("dtack and busError high in the same cycle");
		end

	// Release only once the CPU has dropped AS
	ackRelease: assert property (@(posedge clk24M) disable iff (reset)
		$fell(dtack) |-> !$past(addrStrobe))
		else begin
			failCount++;
			$error("dtack fell while addrStrobe was still high");
		end

	// ROM port only in ROM regions and never once acknowledged
	romOnly: assert property (@(posedge clk24M) disable iff (reset)
		romRead |-> (region == cartRom || region == biosRom) && !dtack && !busError)
		else begin
			failCount++;
			$error("romRead high outside a ROM cycle or after the acknowledge");
		end

endmodule

bind busCycleCtrl neoSysBus_sva i_neoSysBus_sva (.*);

// File: neoSysBus.sv
`timescale 1ns/1ps

// CPU to memory glue, top level
module neoSysBus (
	input  logic                                clk24M,
	input  logic                                reset,
	input  logic [m68kBusPkg::addrWidth-1:0]    cpuAddr,
	input  m68kBusPkg::busWordT                 cpuWriteData,
	input  logic                                cpuRead,     // High for read
	input  m68kBusPkg::byteStrobesT             dataStrobes, // {UDS, LDS}
	input  logic                                addrStrobe,
	output m68kBusPkg::busWordT                 cpuReadData,
	output logic                                dtack,
	output logic                                busError,
	output logic [neoMapPkg::romAddrWidth-1:0]  romAddress,
	output logic                                romCart,
	output logic                                romRead,
	input  m68kBusPkg::busWordT                 romData,
	output logic                                shadow
);
	import m68kBusPkg::*;
	import neoMapPkg::*;

	regionT       region;
	logic [12:0]  ramAddress;
	logic         cartVectors, palBank;
	logic         workWrite, paletteWrite, latchWrite;
	busWordT      ramWriteData;
	busWordT      workReadData;
	paletteEntryT paletteReadData;

	regionDecoder i_regionDecoder (
		.cpuAddr, .cartVectors, .palBank,
		.region, .romAddress, .romCart, .ramAddress
	);

	systemLatch i_systemLatch (
		.clk24M, .reset, .latchWrite,
		.latchAddr(cpuAddr[3:0]), // A4 to A1
		.shadow, .cartVectors, .palBank
	);

	busCycleCtrl i_busCycleCtrl (
		.clk24M, .reset, .addrStrobe, .cpuRead, .dataStrobes, .cpuWriteData,
		.region, .romData, .workReadData, .paletteReadData,
		.dtack, .busError, .cpuReadData, .romRead,
		.workWrite, .paletteWrite, .ramWriteData, .latchWrite
	);

	syncRam #(.wordT(busWordT)) i_workRam (
		.clk24M, .writeEnable(workWrite), .address(ramAddress),
		.writeData(ramWriteData), .readData(workReadData)
	);

	syncRam #(.wordT(paletteEntryT)) i_paletteRam ( // Both banks in one array
		.clk24M, .writeEnable(paletteWrite), .address(ramAddress),
		.writeData(ramWriteData), .readData(paletteReadData)
	);

endmodule

// File: busCycleCtrl.sv
`timescale 1ns/1ps

// One 68000 bus cycle from AS to DTACK
// Wait states per region, RAM writes as read-modify-write
module busCycleCtrl (
	input  logic                    clk24M,
	input  logic                    reset,
	input  logic                    addrStrobe,
	input  logic                    cpuRead,
	input  m68kBusPkg::byteStrobesT dataStrobes,
	input  m68kBusPkg::busWordT     cpuWriteData,
	input  neoMapPkg::regionT       region,
	input  m68kBusPkg::busWordT     romData,
	input  m68kBusPkg::busWordT     workReadData,
	input  neoMapPkg::paletteEntryT paletteReadData,
	output logic                    dtack,
	output logic                    busError,
	output m68kBusPkg::busWordT     cpuReadData,
	output logic                    romRead,
	output logic                    workWrite,
	output logic                    paletteWrite,
	output m68kBusPkg::busWordT     ramWriteData,
	output logic                    latchWrite
);
	import m68kBusPkg::*;
	import neoMapPkg::*;

	typedef enum logic [1:0] {idleSt, waitSt, ackSt} cycleStateT;

	cycleStateT state;
	logic [1:0] waitCnt;  // Clocks left before acknowledge
	logic       lastWait; // Cycle before DTACK rises
	logic       romCycle;
	logic       writeCycle;
	busWordT    ramOldWord;
	busWordT    readMux;

	assign lastWait   = (state == waitSt) && (waitCnt == '0);
	assign romCycle   = (region == cartRom) || (region == biosRom);
	assign writeCycle = lastWait && !cpuRead;

	// ROM port held until the acknowledge edge
	assign romRead = (state == waitSt) && cpuRead && romCycle;

	// Write strobes land on the acknowledge edge
	assign workWrite    = writeCycle && (region == workRam);
	assign paletteWrite = writeCycle && (region == paletteRam);
	assign latchWrite   = writeCycle && (region == sysLatch);

	// Merge strobed bytes into the stored word
	always_comb begin
		if (region == paletteRam)
			ramOldWord = paletteReadData;
		else
			ramOldWord = workReadData;
		ramWriteData = ramOldWord;
		if (dataStrobes[upperStrobe])
			ramWriteData[dataWidth-1:byteWidth] = cpuWriteData[dataWidth-1:byteWidth];
		if (dataStrobes[lowerStrobe])
			ramWriteData[byteWidth-1:0] = cpuWriteData[byteWidth-1:0];
	end

	// Read source, whole word even for byte reads
	always_comb begin
		case (region)
			cartRom, biosRom: readMux = romData;
			workRam:          readMux = workReadData;
			paletteRam:       readMux = paletteReadData;
			default:          readMux = openBusWord; // Latch is write-only
		endcase
	end

	always_ff @(posedge clk24M) begin
		if (lastWait && cpuRead)
			cpuReadData <= readMux; // Held while DTACK is high
	end

	always_ff @(posedge clk24M) begin
		if (reset) begin
			state    <= idleSt;
			waitCnt  <= '0;
			dtack    <= 1'b0;
			busError <= 1'b0;
		end else begin
			case (state)
				idleSt: if (addrStrobe) begin
					state   <= waitSt;
					waitCnt <= 2'(waitStates[region] + 1); // Ack at 2 + waits
				end
				waitSt: if (waitCnt == '0) begin
					state    <= ackSt;
					dtack    <= region != unmapped;
					busError <= region == unmapped; // Nobody decoded it
				end else begin
					waitCnt <= waitCnt - 2'd1;
				end
				ackSt: if (!addrStrobe) begin // CPU ends the cycle
					state    <= idleSt;
					dtack    <= 1'b0;
					busError <= 1'b0;
				end
				default: state <= idleSt;
			endcase
		end
	end

endmodule

// File: syncRam.sv
`timescale 1ns/1ps

// Single port RAM, registered read
module syncRam #(
	parameter type wordT = logic [15:0]
) (
	input  logic        clk24M,
	input  logic        writeEnable,
	input  logic [12:0] address,
	input  wordT        writeData,
	output wordT        readData
);

	localparam int depth = 2 ** $bits(address); // 8192 words

	wordT mem [depth];

	always_ff @(posedge clk24M) begin
		if (writeEnable)
			mem[address] <= writeData;
		readData <= mem[address]; // Old word on a write cycle
	end

endmodule

// File: systemLatch.sv
`timescale 1ns/1ps

// Write-only flag latch at 0x3A0000
// Data lines are not connected, the address carries the value
module systemLatch (
	input  logic       clk24M,
	input  logic       reset,
	input  logic       latchWrite, // One cycle pulse from the bus controller
	input  logic [3:0] latchAddr,  // A4 to A1
	output logic       shadow,
	output logic       cartVectors,
	output logic       palBank
);
	import neoMapPkg::*;

	logic [7:0] flags; // Eight one-bit registers
	logic [2:0] flagSel;
	logic       flagValue;

	assign flagSel   = latchAddr[2:0]; // A3 to A1
	assign flagValue = latchAddr[3];   // A4 is the new value

	always_ff @(posedge clk24M) begin
		if (reset) begin
			flags <= '0; // BIOS vectors, no shadow, bank 0
		end else if (latchWrite) begin
			flags[flagSel] <= flagValue;
		end
	end

	// Flags used by this board model
	assign shadow      = flags[shadowFlag];
	assign cartVectors = flags[cartVectorFlag];
	assign palBank     = flags[palBankFlag];

	// Other flags (card, SRAM lock, ...) stay internal

endmodule

// File: regionDecoder.sv
`timescale 1ns/1ps

// Address decode for the 68000 side
module regionDecoder (
	input  logic [m68kBusPkg::addrWidth-1:0]    cpuAddr,     // A23 to A1
	input  logic                                cartVectors, // Latch flag, vectors from cart
	input  logic                                palBank,     // Latch flag, palette bank
	output neoMapPkg::regionT                   region,
	output logic [neoMapPkg::romAddrWidth-1:0]  romAddress,
	output logic                                romCart,
	output logic [12:0]                         ramAddress
);
	import neoMapPkg::*;

	localparam int workBits = $clog2(workRamWords); // 10
	localparam int palBits  = $clog2(paletteWords); // 12
	localparam int biosBits = $clog2(biosWords);    // 16

	logic [23:0] byteAddr;
	logic        inVectors;

	assign byteAddr  = {cpuAddr, 1'b0};
	assign inVectors = byteAddr < vectorLimit; // First 128 bytes

	always_comb begin
		if ((byteAddr & cartMask) == cartBase)
			region = (inVectors && !cartVectors) ? biosRom : cartRom; // Vector swap
		else if ((byteAddr & workMask) == workBase)
			region = workRam;
		else if ((byteAddr & latchMask) == latchBase)
			region = sysLatch;
		else if ((byteAddr & paletteMask) == paletteBase)
			region = paletteRam;
		else if ((byteAddr & biosMask) == biosBase)
			region = biosRom;
		else
			region = unmapped; // Ends in bus error
	end

	// Cart gets its offset straight, BIOS only the low 64K words
	assign romCart = region == cartRom;

	always_comb begin
		if (romCart)
			romAddress = cpuAddr[romAddrWidth-1:0];
		else
			romAddress = romAddrWidth'(cpuAddr[biosBits-1:0]); // Also vector reads
	end

	// Work RAM repeats every 2 KB, palette bank on top bit
	always_comb begin
		ramAddress = '0;
		if (region == paletteRam)
			ramAddress = {palBank, cpuAddr[palBits-1:0]};
		else
			ramAddress[workBits-1:0] = cpuAddr[workBits-1:0]; // Mirrored
	end

endmodule

// File: neoMapPkg.sv
// Board memory map and system latch layout
package neoMapPkg;

	// Who answers a bus cycle
	typedef enum logic [2:0] {
		cartRom,
		biosRom,
		workRam,
		paletteRam,
		sysLatch,
		unmapped
	} regionT;

	// Byte address windows, base and mask
	localparam logic [23:0] cartBase    = 24'h000000; // P ROM, 1 MB
	localparam logic [23:0] cartMask    = 24'hF00000;
	localparam logic [23:0] workBase    = 24'h100000; // 64 KB window
	localparam logic [23:0] workMask    = 24'hFF0000;
	localparam logic [23:0] latchBase   = 24'h3A0000; // 32 bytes of flags
	localparam logic [23:0] latchMask   = 24'hFFFFE0;
	localparam logic [23:0] paletteBase = 24'h400000; // 8 KB per bank
	localparam logic [23:0] paletteMask = 24'hFFE000;
	localparam logic [23:0] biosBase    = 24'hC00000; // 128 KB system ROM
	localparam logic [23:0] biosMask    = 24'hFE0000;

	// Vector table, swappable between BIOS and cartridge
	localparam logic [23:0] vectorLimit = 24'h000080;

	// Extra clocks per region, indexed by regionT
	localparam int waitStates [6] = '{2, 2, 0, 1, 0, 0};

	// On chip RAM sizes in words
	localparam int workRamWords = 1024; // 2 KB, mirrored over the window
	localparam int paletteWords = 4096; // Per bank
	localparam int biosWords    = 65536;

	// Word address width on the ROM port, covers 1 MB of cartridge
	localparam int romAddrWidth = 19;

	// Latch flag numbers, picked by A3 to A1
	localparam int shadowFlag     = 0;
	localparam int cartVectorFlag = 1;
	localparam int palBankFlag    = 7;

	// Palette word, dark bit and colour LSBs on top
	typedef struct packed {
		logic       dark;
		logic       redLsb;
		logic       greenLsb;
		logic       blueLsb;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} paletteEntryT;

endpackage

// File: m68kBusPkg.sv
// Generic 68000 bus description
// Only what the CPU side of the glue needs
package m68kBusPkg;

	// A23 to A1, no A0 on the 68000
	localparam int addrWidth = 23;

	// Full byte address as seen on a logic analyser
	localparam int byteAddrWidth = addrWidth + 1;

	// Data bus D15 to D0
	localparam int dataWidth = 16;

	// Strobe bit positions inside byteStrobesT
	localparam int upperStrobe = 1; // UDS, D15 to D8
	localparam int lowerStrobe = 0; // LDS, D7 to D0

	// One bus word
	typedef logic [dataWidth-1:0] busWordT;

	// Active high data strobes {UDS, LDS}
	typedef logic [1:0] byteStrobesT;

	// Handy for the byte lanes
	localparam int byteWidth = dataWidth / 2;

	// Value floated back on reads nobody answers
	localparam busWordT openBusWord = '1;

	// Word address type, used for the CPU address bus
	typedef logic [addrWidth-1:0] wordAddrT;

	// Byte address type, 24 bits
	typedef logic [byteAddrWidth-1:0] byteAddrT;

endpackage
